// ==== rtl/hisPkg.sv ====
package hisPkg;

    // time-code width from the TDC front end
    localparam int NP = 10;

    // histogram address width, 32 bins per pass
    localparam int NB = 5;

    // width needed to hold a shift amount up to NP
    localparam int SHIFT_W = $clog2(NP + 1);

    // default bin counter width, also the result count width
    localparam int DEFAULT_CNT_W = 8;

    // current histogram pass
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } PHASE_E;

    // combined result of one coarse plus one fine pass
    typedef struct packed {
        logic [NB-1:0]            coarseBin;
        logic [NB-1:0]            fineBin;
        logic [NP-1:0]            peakTime;
        logic [DEFAULT_CNT_W-1:0] peakCount;
    } peakResult_t;

endpackage

// ==== rtl/binBusIf.sv ====
interface binBusIf #(
    parameter int CNT_W = hisPkg::DEFAULT_CNT_W
);

    // increment request from the formatter
    logic                  incEn;
    logic [hisPkg::NB-1:0] incAddr;

    // read-and-clear request from the control FSM
    logic                  rdEn;
    logic [hisPkg::NB-1:0] rdAddr;

    // read return, bin address travels with the count
    logic                  rdValid;
    logic [hisPkg::NB-1:0] rdBin;
    logic [CNT_W-1:0]      rdCount;

    modport ctrl (output rdEn, output rdAddr);

    modport fmt (output incEn, output incAddr);

    modport mem (
        input  incEn, input  incAddr,
        input  rdEn,  input  rdAddr,
        output rdValid, output rdBin, output rdCount
    );

    modport mon (input rdValid, input rdBin, input rdCount);

endinterface

// ==== rtl/dataFormatter.sv ====
module dataFormatter (
    input  logic [hisPkg::NP-1:0]      roughData,
    input  logic                       accept,
    input  hisPkg::PHASE_E             phase,
    input  logic [hisPkg::NP-1:0]      winStart,
    input  logic [hisPkg::NP-1:0]      winEnd,
    input  logic [hisPkg::SHIFT_W-1:0] fineShift,
    binBusIf.fmt                       bus
);

    logic [hisPkg::NP-1:0] offset;
    logic [hisPkg::NP-1:0] fineIdx;
    logic                  inWindow;

    // offset of the code from the window start
    assign offset = roughData - winStart;

    // fine bin index, window splits into 2^NB bins
    assign fineIdx = offset >> fineShift;

    // inclusive window check
    assign inWindow = (roughData >= winStart) && (roughData <= winEnd);

    always_comb begin
        if (phase == hisPkg::COARSE) begin
            // coarse pass, top NB bits select the bin
            bus.incAddr = roughData[hisPkg::NP-1 -: hisPkg::NB];
            bus.incEn   = accept;
        end else begin
            // fine pass, only in-window codes count
            bus.incAddr = fineIdx[hisPkg::NB-1:0];
            bus.incEn   = accept && inWindow;
        end
    end

endmodule

// ==== rtl/binCounter.sv ====
module binCounter #(
    parameter int CNT_W = hisPkg::DEFAULT_CNT_W
) (
    input  logic clk,
    input  logic rst,
    binBusIf.mem bus
);

    localparam int NBINS = 2 ** hisPkg::NB;

    // per-bin count, gathered for the read mux
    logic [CNT_W-1:0] binVal [NBINS];

    for (genvar i = 0; i < NBINS; i++) begin : gBin
        logic [CNT_W-1:0] cnt;
        logic             clrHit;
        logic             incHit;

        // this bin is being read and cleared
        assign clrHit = bus.rdEn && (bus.rdAddr == hisPkg::NB'(i));

        // this bin gets a hit this cycle
        assign incHit = bus.incEn && (bus.incAddr == hisPkg::NB'(i));

        always_ff @(posedge clk) begin
            if (rst) begin
                cnt <= '0;
            end else if (clrHit && incHit) begin
                // increment lands after the clear
                cnt <= CNT_W'(1);
            end else if (clrHit) begin
                cnt <= '0;
            end else if (incHit && (cnt != '1)) begin
                // saturate at all ones
                cnt <= cnt + CNT_W'(1);
            end
        end

        assign binVal[i] = cnt;

        // a full bin stays full under further hits
        assert property (@(posedge clk) disable iff (rst)
            (incHit && !clrHit && (cnt == '1)) |=> (cnt == '1));
    end

    // read valid, one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.rdValid <= 1'b0;
        end else begin
            bus.rdValid <= bus.rdEn;
        end
    end

    // returned count and its bin address
    always_ff @(posedge clk) begin
        if (bus.rdEn) begin
            bus.rdCount <= binVal[bus.rdAddr];
            bus.rdBin   <= bus.rdAddr;
        end
    end

endmodule

// ==== rtl/peakDetector.sv ====
module peakDetector #(
    parameter int CNT_W = hisPkg::DEFAULT_CNT_W
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  scanStart,
    binBusIf.mon                  bus,
    output logic                  peakValid,
    output logic [hisPkg::NB-1:0] peakBin,
    output logic [CNT_W-1:0]      peakCount
);

    logic [hisPkg::NB-1:0] bestBin;
    logic [CNT_W-1:0]      bestCount;
    logic                  lastBin;

    // return for the highest bin closes the scan
    assign lastBin = bus.rdValid && (bus.rdBin == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            bestBin   <= '0;
            bestCount <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= lastBin;
            if (scanStart) begin
                // fresh scan, bin 0 holds by default
                bestBin   <= '0;
                bestCount <= '0;
            end else if (bus.rdValid && (bus.rdCount > bestCount)) begin
                // strictly greater, so lowest bin wins ties
                bestBin   <= bus.rdBin;
                bestCount <= bus.rdCount;
            end
        end
    end

    assign peakBin   = bestBin;
    assign peakCount = bestCount;

    // returns from the FSM walk arrive back to back in bin order
    assert property (@(posedge clk) disable iff (rst)
        (bus.rdValid && (bus.rdBin != '1)) |=>
            (bus.rdValid && (bus.rdBin == $past(bus.rdBin) + hisPkg::NB'(1))));

endmodule

// ==== rtl/windowCalc.sv ====
module windowCalc (
    input  logic [hisPkg::NB-1:0]      coarseBin,
    output logic [hisPkg::NP-1:0]      winStart,
    output logic [hisPkg::NP-1:0]      winEnd,
    output logic [hisPkg::SHIFT_W-1:0] fineShift
);

    // low bits of the code below the coarse bin
    localparam int LOW_W = hisPkg::NP - hisPkg::NB;

    // width of one coarse bin in code units
    localparam logic [hisPkg::NP-1:0] BIN_SPAN = hisPkg::NP'(2 ** LOW_W);

    // coarse bin back in the top bits of a code
    assign winStart = {coarseBin, {LOW_W{1'b0}}};

    // last code inside the coarse bin
    assign winEnd = winStart + BIN_SPAN - hisPkg::NP'(1);

    // split the window into 2^NB fine bins
    assign fineShift = hisPkg::SHIFT_W'(hisPkg::NP - 2 * hisPkg::NB);

endmodule

// ==== rtl/hisBuilderFsm.sv ====
module hisBuilderFsm #(
    parameter int CNT_W     = hisPkg::DEFAULT_CNT_W,
    parameter int ACQ_COUNT = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wrEn,
    binBusIf.ctrl                      bus,
    input  logic                       peakValid,
    input  logic [hisPkg::NB-1:0]      peakBin,
    input  logic [CNT_W-1:0]           peakCount,
    input  logic [hisPkg::NP-1:0]      winStart,
    input  logic [hisPkg::SHIFT_W-1:0] fineShift,
    output logic                       accept,
    output hisPkg::PHASE_E             phase,
    output logic                       scanStart,
    output logic                       busy,
    output logic                       done,
    output logic [hisPkg::NB-1:0]      coarseBin,
    output hisPkg::peakResult_t        result
);

    localparam int ACQ_W     = $clog2(ACQ_COUNT + 1);
    localparam int RES_CNT_W = hisPkg::DEFAULT_CNT_W;

    typedef enum logic [1:0] {
        ACQ,
        SCAN,
        DRAIN
    } fsmState_e;

    fsmState_e             state;
    logic [ACQ_W-1:0]      acqCnt;
    logic [hisPkg::NB-1:0] scanAddr;
    logic [hisPkg::NP-1:0] fineTime;

    // samples only taken while acquiring
    assign accept = wrEn && (state == ACQ);
    assign busy   = (state != ACQ);

    // one read-and-clear per scan cycle
    assign bus.rdEn   = (state == SCAN);
    assign bus.rdAddr = scanAddr;
    assign scanStart  = (state == SCAN) && (scanAddr == '0);

    // window start plus scaled fine offset
    assign fineTime = winStart +
        ({{(hisPkg::NP - hisPkg::NB){1'b0}}, peakBin} << fineShift);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ACQ;
            phase     <= hisPkg::COARSE;
            acqCnt    <= '0;
            scanAddr  <= '0;
            done      <= 1'b0;
            coarseBin <= '0;
            result    <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ACQ: begin
                    if (accept) begin
                        if (acqCnt == ACQ_W'(ACQ_COUNT - 1)) begin
                            // pass full so the scan starts
                            acqCnt   <= '0;
                            scanAddr <= '0;
                            state    <= SCAN;
                        end else begin
                            acqCnt <= acqCnt + ACQ_W'(1);
                        end
                    end
                end
                SCAN: begin
                    scanAddr <= scanAddr + hisPkg::NB'(1);
                    // last bin read then wait for the peak
                    if (scanAddr == '1) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (peakValid) begin
                        state <= ACQ;
                        if (phase == hisPkg::COARSE) begin
                            // coarse peak sets the fine window
                            coarseBin <= peakBin;
                            phase     <= hisPkg::FINE;
                        end else begin
                            result.coarseBin <= coarseBin;
                            result.fineBin   <= peakBin;
                            result.peakTime  <= fineTime;
                            result.peakCount <= RES_CNT_W'(peakCount);
                            done             <= 1'b1;
                            phase            <= hisPkg::COARSE;
                        end
                    end
                end
                default: begin
                    state <= ACQ;
                end
            endcase
        end
    end

    // a peak only shows up while the FSM waits for it
    assert property (@(posedge clk) disable iff (rst) peakValid |-> (state == DRAIN));

endmodule

// ==== rtl/hisBuilderTop.sv ====
module hisBuilderTop #(
    parameter int CNT_W     = hisPkg::DEFAULT_CNT_W,
    parameter int ACQ_COUNT = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wrEn,
    input  logic [hisPkg::NP-1:0] roughData,
    output logic                  busy,
    output logic                  done,
    output logic [hisPkg::NB-1:0] peakCH,
    output logic [hisPkg::NB-1:0] peakFH,
    output logic [hisPkg::NP-1:0] peakTime,
    output logic [CNT_W-1:0]      peakCount
);

    logic                       accept;
    logic                       scanStart;
    logic                       peakValid;
    hisPkg::PHASE_E             phase;
    hisPkg::peakResult_t        result;
    logic [hisPkg::NB-1:0]      peakBin;
    logic [CNT_W-1:0]           binPeakCount;
    logic [hisPkg::NB-1:0]      coarseBin;
    logic [hisPkg::NP-1:0]      winStart;
    logic [hisPkg::NP-1:0]      winEnd;
    logic [hisPkg::SHIFT_W-1:0] fineShift;

    binBusIf #(.CNT_W(CNT_W)) bus ();

    hisBuilderFsm #(.CNT_W(CNT_W), .ACQ_COUNT(ACQ_COUNT)) fsmU0 (
        .clk(clk), .rst(rst), .wrEn(wrEn), .bus(bus.ctrl),
        .peakValid(peakValid), .peakBin(peakBin), .peakCount(binPeakCount),
        .winStart(winStart), .fineShift(fineShift), .accept(accept),
        .phase(phase), .scanStart(scanStart), .busy(busy), .done(done),
        .coarseBin(coarseBin), .result(result)
    );

    dataFormatter dfU0 (
        .roughData(roughData), .accept(accept), .phase(phase),
        .winStart(winStart), .winEnd(winEnd), .fineShift(fineShift),
        .bus(bus.fmt)
    );

    binCounter #(.CNT_W(CNT_W)) binU0 (.clk(clk), .rst(rst), .bus(bus.mem));

    peakDetector #(.CNT_W(CNT_W)) peakU0 (
        .clk(clk), .rst(rst), .scanStart(scanStart), .bus(bus.mon),
        .peakValid(peakValid), .peakBin(peakBin), .peakCount(binPeakCount)
    );

    windowCalc winU0 (
        .coarseBin(coarseBin), .winStart(winStart), .winEnd(winEnd),
        .fineShift(fineShift)
    );

    // result struct out as plain ports
    assign peakCH    = result.coarseBin;
    assign peakFH    = result.fineBin;
    assign peakTime  = result.peakTime;
    assign peakCount = CNT_W'(result.peakCount);

endmodule

// ==== verif/hisBuilderTb.sv ====
module hisBuilderTb;

    localparam int NP = hisPkg::NP;
    localparam int NB = hisPkg::NB;
    localparam int BINS = 2 ** NB;
    localparam int LOW_W = NP - NB;
    // enough samples per pass to push one bin past all ones
    localparam int ACQ = 260;
    localparam int SAT_MAX = 2 ** hisPkg::DEFAULT_CNT_W - 1;
    localparam int TIMEOUT = 200;

    logic                             clk, rst, wrEn, busy, done;
    logic [NP-1:0]                    roughData, peakTime;
    logic [NB-1:0]                    peakCH, peakFH;
    logic [hisPkg::DEFAULT_CNT_W-1:0] peakCount;

    // sample sets of the current run
    int coarseSet[$];
    int fineSet[$];
    // model histogram
    int hist[BINS];

    hisBuilderTop #(.ACQ_COUNT(ACQ)) UUT (.*);

    always #50 clk = ~clk;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkBusy(input bit exp, input string what);
        if (busy !== exp) begin
            abortRun($sformatf("mismatch at %0t: busy %s is %b, expected %b",
                $time, what, busy, exp));
        end
    endtask

    task automatic checkResult(input hisPkg::peakResult_t exp, input string what);
        hisPkg::peakResult_t got;
        // result ports packed back in struct order
        got = {peakCH, peakFH, peakTime, peakCount};
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0t: %s got %h %h %h %h, expected %h %h %h %h",
                $time, what, got.coarseBin, got.fineBin, got.peakTime, got.peakCount,
                exp.coarseBin, exp.fineBin, exp.peakTime, exp.peakCount));
        end
    endtask

    // model histogram of one pass where the lowest bin wins ties
    function automatic int passPeak(input bit fine, input int winStart);
        int code;
        int b;
        int best;
        best = 0;
        hist = '{default: 0};
        for (int i = 0; i < (fine ? fineSet.size() : coarseSet.size()); i++) begin
            code = fine ? fineSet[i] : coarseSet[i];
            b = fine ? ((code - winStart) >> (NP - 2 * NB)) : (code >> LOW_W);
            // fine pass only counts codes inside the coarse bin span
            if (!fine || (code >= winStart && code < winStart + 2 ** LOW_W)) begin
                if (hist[b] < SAT_MAX) begin
                    hist[b]++;
                end
            end
        end
        for (int i = 1; i < BINS; i++) begin
            if (hist[i] > hist[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    function automatic hisPkg::peakResult_t expectedResult();
        hisPkg::peakResult_t res;
        int cBin;
        int fBin;
        int winStart;
        cBin = passPeak(1'b0, 0);
        // coarse bin back in the top bits gives the window start
        winStart = cBin << LOW_W;
        fBin = passPeak(1'b1, winStart);
        res.coarseBin = NB'(cBin);
        res.fineBin = NB'(fBin);
        res.peakTime = NP'(winStart + (fBin << (NP - 2 * NB)));
        res.peakCount = hisPkg::DEFAULT_CNT_W'(hist[fBin]);
        return res;
    endfunction

    // idle inputs or junk that must be dropped while busy
    task automatic driveIdle(input bit junk);
        wrEn = junk;
        roughData = NP'($urandom_range(2 ** NP - 1, 0));
    endtask

    // next falling edge with busy low or with done high
    task automatic waitFor(input bit forDone, input bit junk);
        int waitCnt;
        string what;
        waitCnt = 0;
        what = "busy to fall";
        if (forDone) begin
            what = "done";
        end
        @(negedge clk);
        while (forDone ? !done : busy) begin
            driveIdle(junk);
            waitCnt++;
            if (waitCnt > TIMEOUT) begin
                abortRun({"timed out waiting for ", what});
            end
            @(negedge clk);
        end
    endtask

    // coarse then fine pass through the DUT checked against the model
    task automatic runHistogram(input bit junk, input string what);
        hisPkg::peakResult_t exp;
        exp = expectedResult();
        foreach (coarseSet[i]) begin
            waitFor(1'b0, junk);
            wrEn = 1'b1;
            roughData = NP'(coarseSet[i]);
        end
        // last coarse sample taken, scan must be running
        @(negedge clk);
        driveIdle(junk);
        checkBusy(1'b1, "after coarse pass");
        foreach (fineSet[i]) begin
            waitFor(1'b0, junk);
            wrEn = 1'b1;
            roughData = NP'(fineSet[i]);
        end
        @(negedge clk);
        driveIdle(junk);
        checkBusy(1'b1, "after fine pass");
        waitFor(1'b1, junk);
        wrEn = 1'b0;
        checkResult(exp, what);
        checkBusy(1'b0, "with done");
        coarseSet.delete();
        fineSet.delete();
    endtask

    // two codes per pass with the first one repeated nC or nF times
    task automatic runTwoCodes(input int cA, input int cB, input int nC, input int fA,
                               input int fB, input int nF, input string what);
        for (int i = 0; i < ACQ; i++) begin
            coarseSet.push_back(i < nC ? cA : cB);
            fineSet.push_back(i < nF ? fA : fB);
        end
        runHistogram(1'b0, what);
    endtask

    task automatic runRandomSets(input bit junk, input int runs, input string what);
        int winStart;
        for (int r = 0; r < runs; r++) begin
            for (int i = 0; i < ACQ; i++) begin
                coarseSet.push_back(int'($urandom_range(2 ** NP - 1, 0)));
            end
            // most fine codes land inside the expected window
            winStart = passPeak(1'b0, 0) << LOW_W;
            for (int i = 0; i < ACQ; i++) begin
                if ($urandom_range(3, 0) != 0) begin
                    fineSet.push_back(winStart + int'($urandom_range(2 ** LOW_W - 1, 0)));
                end else begin
                    fineSet.push_back(int'($urandom_range(2 ** NP - 1, 0)));
                end
            end
            runHistogram(junk, what);
        end
    endtask

    initial begin
        void'($urandom(51));
        clk = 1'b0;
        rst = 1'b1;
        wrEn = 1'b0;
        roughData = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkBusy(1'b0, "after reset");
        if (done !== 1'b0) begin
            abortRun($sformatf("mismatch at %0t: done after reset is %b, expected 0",
                $time, done));
        end
        checkResult('0, "after reset");
        // clear coarse majority and a fine cluster at offset 7
        runTwoCodes((12 << LOW_W) + 5, 3 << LOW_W, 160,
            (12 << LOW_W) + 7, (12 << LOW_W) + 9, 150, "majority");
        // more codes just outside the window than inside it
        runTwoCodes((20 << LOW_W) + 9, 3 << LOW_W, 200,
            (20 << LOW_W) + 3, (21 << LOW_W) + 1, 60, "out of window");
        // equal counts in both passes
        runTwoCodes(7 << LOW_W, (25 << LOW_W) + 1, 130,
            (7 << LOW_W) + 20, (7 << LOW_W) + 4, 130, "tie");
        // every sample in one bin
        runTwoCodes((21 << LOW_W) + 5, 0, ACQ, (21 << LOW_W) + 5, 0, ACQ, "saturation");
        runRandomSets(1'b1, 2, "random run with dropped samples");
        runRandomSets(1'b0, 3, "random run");
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/hisPkg.sv
rtl/binBusIf.sv
rtl/dataFormatter.sv
rtl/binCounter.sv
rtl/peakDetector.sv
rtl/windowCalc.sv
rtl/hisBuilderFsm.sv
rtl/hisBuilderTop.sv
verif/hisBuilderTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module hisBuilderTb -f src.f -o hisBuilderSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi
./obj_dir/hisBuilderSim > sim.log 2>&1
simStatus=$?
cat sim.log
if grep -q "Regression failed" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
exit 0
